//--- source/div_arith_pkg.sv
`default_nettype none

package div_arith_pkg;

    // operand and result width of the divider.
    localparam int data_width = 32;

    // the quotient is a fixed-point value with this many fraction bits.
    localparam int frac_bits = 10;

    localparam int count_width = $clog2(data_width + 1);

    // both the job queue and the result queue use this depth.
    localparam int queue_depth = 4;

    typedef struct packed {
        logic [data_width-1:0] dividend;
        logic [data_width-1:0] divisor;
    } div_job_t;

    typedef struct packed {
        logic [data_width-1:0] quotient;
        logic [data_width-1:0] remainder;
        logic                  div_by_zero;
    } div_result_t;

endpackage

`default_nettype wire

//--- source/axil_regs_pkg.sv
`default_nettype none

package axil_regs_pkg;

    localparam int addr_width      = 8;
    localparam int axil_data_width = 32;
    localparam int axil_strb_width = axil_data_width / 8;

    typedef struct packed {
        logic [addr_width-1:0]      awaddr;
        logic                       awvalid;
        logic [axil_data_width-1:0] wdata;
        logic [axil_strb_width-1:0] wstrb;
        logic                       wvalid;
        logic                       bready;
        logic [addr_width-1:0]      araddr;
        logic                       arvalid;
        logic                       rready;
    } axil_req_t;

    typedef struct packed {
        logic                       awready;
        logic                       wready;
        logic [1:0]                 bresp;
        logic                       bvalid;
        logic                       arready;
        logic [axil_data_width-1:0] rdata;
        logic [1:0]                 rresp;
        logic                       rvalid;
    } axil_rsp_t;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;
    localparam logic [1:0] resp_decerr = 2'b11;

    localparam logic [addr_width-1:0] reg_dividend  = 8'h00;
    localparam logic [addr_width-1:0] reg_divisor   = 8'h04;
    localparam logic [addr_width-1:0] reg_launch    = 8'h08;
    localparam logic [addr_width-1:0] reg_status    = 8'h0C;
    localparam logic [addr_width-1:0] reg_quotient  = 8'h10;
    localparam logic [addr_width-1:0] reg_remainder = 8'h14;

    // bit positions inside the status word.
    localparam int status_result_bit = 0;
    localparam int status_full_bit   = 1;
    localparam int status_dbz_bit    = 2;

endpackage

`default_nettype wire

//--- source/sync_queue.sv
`timescale 1ns/1ps
`default_nettype none

module sync_queue #(
    parameter type         payload_t = logic [7:0],
    parameter int unsigned depth     = 4
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    localparam int ptr_width   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    payload_t               mem [depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic                   push;
    logic                   pop;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        return (ptr == ptr_width'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = (count != count_width'(depth));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // a push and a pop in the same cycle leave the count as it is.
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- source/nonrestoring_divider.sv
`timescale 1ns/1ps
`default_nettype none

module nonrestoring_divider (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       in_valid,
    input  div_arith_pkg::div_job_t    in_job,
    output logic                       in_ready,
    output logic                       out_valid,
    output div_arith_pkg::div_result_t out_result,
    input  logic                       out_ready
);

    import div_arith_pkg::*;

    localparam int msb = 2 * data_width;

    typedef enum logic [1:0] {
        st_idle,
        st_iterate,
        st_done
    } state_t;

    state_t                 state;
    logic [count_width-1:0] count;
    logic                   accept;
    logic                   last_step;

    // sign, partial remainder and quotient form one shift register.
    logic [msb:0]            eaq;
    logic [msb:0]            eaq_step;
    logic [data_width:0]     rem_shift;
    logic [data_width:0]     rem_sum;
    logic [data_width:0]     rem_final;
    logic [data_width-1:0]   divisor;
    logic [data_width-1:0]   shifted_dividend;
    logic                    div_by_zero;

    assign accept           = in_valid && in_ready;
    assign last_step        = (count == count_width'(data_width - 1));
    assign shifted_dividend = in_job.dividend << frac_bits;

    always_comb begin
        rem_shift = eaq[msb-1:data_width-1];
        // the sign of the old partial remainder picks add or subtract.
        if (eaq[msb]) begin
            rem_sum = rem_shift + {1'b0, divisor};
        end else begin
            rem_sum = rem_shift - {1'b0, divisor};
        end
        rem_final = rem_sum;
        if (last_step && rem_sum[data_width]) begin
            rem_final = rem_sum + {1'b0, divisor};
        end
        eaq_step = {rem_final, eaq[data_width-2:0], ~rem_sum[data_width]};
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_iterate;
                        count <= '0;
                    end
                end
                st_iterate: begin
                    count <= count + 1'b1;
                    if (last_step) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    if (out_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            eaq         <= {1'b0, {data_width{1'b0}}, shifted_dividend};
            divisor     <= in_job.divisor;
            div_by_zero <= (in_job.divisor == '0);
        end else if (state == st_iterate) begin
            eaq <= eaq_step;
        end
    end

    assign in_ready  = (state == st_idle);
    assign out_valid = (state == st_done);

    always_comb begin
        out_result.quotient    = eaq[data_width-1:0];
        out_result.remainder   = eaq[msb-1:data_width];
        out_result.div_by_zero = div_by_zero;
    end

endmodule

`default_nettype wire

//--- source/axil_div_regs.sv
`timescale 1ns/1ps
`default_nettype none

module axil_div_regs (
    input  logic                       clock,
    input  logic                       reset,
    input  axil_regs_pkg::axil_req_t   axil_req,
    output axil_regs_pkg::axil_rsp_t   axil_rsp,
    output logic                       job_valid,
    output div_arith_pkg::div_job_t    job,
    input  logic                       job_ready,
    input  logic                       result_valid,
    input  div_arith_pkg::div_result_t result,
    output logic                       result_pop
);

    import div_arith_pkg::*;
    import axil_regs_pkg::*;

    div_job_t                   operands;
    logic                       write_fire;
    logic                       read_fire;
    logic                       launch_ok;
    logic                       bvalid;
    logic                       rvalid;
    logic [1:0]                 bresp;
    logic [1:0]                 rresp;
    logic [1:0]                 write_code;
    logic [1:0]                 read_code;
    logic [axil_data_width-1:0] rdata;
    logic [axil_data_width-1:0] read_word;
    logic [axil_data_width-1:0] status_word;

    function automatic logic [data_width-1:0] merge_bytes(
        input logic [data_width-1:0]      old_value,
        input logic [axil_data_width-1:0] new_value,
        input logic [axil_strb_width-1:0] strobe
    );
        logic [data_width-1:0] merged;
        merged = old_value;
        for (int b = 0; b < axil_strb_width; b++) begin
            if (strobe[b]) begin
                merged[8*b +: 8] = new_value[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // address and data are taken together, one transaction at a time.
    assign write_fire = axil_req.awvalid && axil_req.wvalid && !bvalid;
    assign read_fire  = axil_req.arvalid && !rvalid;

    always_comb begin
        status_word = '0;
        status_word[status_result_bit] = result_valid;
        status_word[status_full_bit]   = !job_ready;
        status_word[status_dbz_bit]    = result_valid && result.div_by_zero;
    end

    always_comb begin
        launch_ok = 1'b0;
        case (axil_req.awaddr)
            reg_dividend, reg_divisor: begin
                write_code = resp_okay;
            end
            reg_launch: begin
                launch_ok  = job_ready;
                write_code = job_ready ? resp_okay : resp_slverr;
            end
            default: begin
                write_code = resp_decerr;
            end
        endcase
    end

    always_comb begin
        read_word = '0;
        read_code = resp_okay;
        case (axil_req.araddr)
            reg_dividend: read_word = operands.dividend;
            reg_divisor:  read_word = operands.divisor;
            reg_status:   read_word = status_word;
            reg_quotient: begin
                if (result_valid) begin
                    read_word = result.quotient;
                end else begin
                    read_code = resp_slverr;
                end
            end
            reg_remainder: begin
                if (result_valid) begin
                    read_word = result.remainder;
                end else begin
                    read_code = resp_slverr;
                end
            end
            default: read_code = resp_decerr;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            operands   <= '0;
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
            job_valid  <= 1'b0;
            result_pop <= 1'b0;
        end else begin
            job_valid  <= write_fire && launch_ok;
            // the head result leaves the queue once its remainder has been read.
            result_pop <= read_fire && result_valid && (axil_req.araddr == reg_remainder);
            if (write_fire) begin
                bvalid <= 1'b1;
                if (axil_req.awaddr == reg_dividend) begin
                    operands.dividend <= merge_bytes(operands.dividend, axil_req.wdata,
                                                     axil_req.wstrb);
                end
                if (axil_req.awaddr == reg_divisor) begin
                    operands.divisor <= merge_bytes(operands.divisor, axil_req.wdata,
                                                    axil_req.wstrb);
                end
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (read_fire) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_fire) begin
            bresp <= write_code;
        end
        if (read_fire) begin
            rdata <= read_word;
            rresp <= read_code;
        end
    end

    // operands cannot change while a pushed job is pending, so the job reads them directly.
    assign job = operands;

    always_comb begin
        axil_rsp.awready = write_fire;
        axil_rsp.wready  = write_fire;
        axil_rsp.bresp   = bresp;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.arready = !rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
        axil_rsp.rvalid  = rvalid;
    end

endmodule

`default_nettype wire

//--- source/div_accel_top.sv
`timescale 1ns/1ps
`default_nettype none

module div_accel_top (
    input  logic                     clock,
    input  logic                     reset,
    input  axil_regs_pkg::axil_req_t axil_req,
    output axil_regs_pkg::axil_rsp_t axil_rsp
);

    import div_arith_pkg::*;

    logic        job_valid;
    div_job_t    job;
    logic        job_ready;
    logic        div_in_valid;
    div_job_t    div_in_job;
    logic        div_in_ready;
    logic        div_out_valid;
    div_result_t div_out_result;
    logic        div_out_ready;
    logic        result_valid;
    div_result_t result;
    logic        result_pop;

    axil_div_regs i_regs (
        .clock       (clock),
        .reset       (reset),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .job_valid   (job_valid),
        .job         (job),
        .job_ready   (job_ready),
        .result_valid(result_valid),
        .result      (result),
        .result_pop  (result_pop)
    );

    sync_queue #(
        .payload_t(div_job_t),
        .depth    (queue_depth)
    ) i_job_queue (
        .clock    (clock),
        .reset    (reset),
        .in_valid (job_valid),
        .in_data  (job),
        .in_ready (job_ready),
        .out_valid(div_in_valid),
        .out_data (div_in_job),
        .out_ready(div_in_ready)
    );

    nonrestoring_divider i_divider (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (div_in_valid),
        .in_job    (div_in_job),
        .in_ready  (div_in_ready),
        .out_valid (div_out_valid),
        .out_result(div_out_result),
        .out_ready (div_out_ready)
    );

    // a full result queue holds the divider in its done state.
    sync_queue #(
        .payload_t(div_result_t),
        .depth    (queue_depth)
    ) i_result_queue (
        .clock    (clock),
        .reset    (reset),
        .in_valid (div_out_valid),
        .in_data  (div_out_result),
        .in_ready (div_out_ready),
        .out_valid(result_valid),
        .out_data (result),
        .out_ready(result_pop)
    );

endmodule

`default_nettype wire

//--- test/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int half_period  = 50,
    parameter int reset_cycles = 2
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    // reset is released on a rising edge, after the flops have seen it.
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- test/div_accel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module div_accel_tb;

    import div_arith_pkg::*;
    import axil_regs_pkg::*;

    // the divider and both queues together hold this many jobs.
    localparam int capacity    = 2 * queue_depth + 1;
    localparam int job_count   = 20 + 1 + capacity + 3;
    localparam int cycle_limit = job_count * (data_width + 20) + 2000;

    logic        clock;
    logic        reset;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic [31:0] lfsr_state;
    int          cycle_count;

    clock_gen #(
        .half_period (50),
        .reset_cycles(2)
    ) i_clock_gen (
        .clock(clock),
        .reset(reset)
    );

    div_accel_top i_dut (
        .clock   (clock),
        .reset   (reset),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp)
    );

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string message);
        $display("[FAIL] %0t: %s", $time, message);
        stop_run();
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            stop_run();
        end
    end

    // taps 32, 22, 2 and 1 give a maximal length sequence.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic div_result_t expected_result(input div_job_t job);
        div_result_t           expected;
        logic [data_width-1:0] shifted;
        // bits shifted past the top of the word are lost.
        shifted = job.dividend << frac_bits;
        expected.div_by_zero = (job.divisor == '0);
        if (expected.div_by_zero) begin
            expected.quotient  = '1;
            expected.remainder = shifted;
        end else begin
            expected.quotient  = shifted / job.divisor;
            expected.remainder = shifted % job.divisor;
        end
        return expected;
    endfunction

    task automatic axil_write(input logic [addr_width-1:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        @(negedge clock);
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        // address and data are taken on the rising edge where both ready signals are high.
        do begin
            @(posedge clock);
        end while (!(axil_rsp.awready && axil_rsp.wready));
        @(negedge clock);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        while (!axil_rsp.bvalid) begin
            @(negedge clock);
        end
        resp = axil_rsp.bresp;
        @(negedge clock);
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [addr_width-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge clock);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        do begin
            @(posedge clock);
        end while (!axil_rsp.arready);
        @(negedge clock);
        axil_req.arvalid = 1'b0;
        while (!axil_rsp.rvalid) begin
            @(negedge clock);
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(negedge clock);
        axil_req.rready = 1'b0;
    endtask

    task automatic check_read(input logic [addr_width-1:0] addr, input logic [31:0] expect_data,
                              input logic [1:0] expect_resp, input string what);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        assert (resp == expect_resp)
            else value_error($sformatf("%s: response %0d, expected %0d", what, resp,
                                       expect_resp));
        assert (data == expect_data)
            else value_error($sformatf("%s: read 0x%08h, expected 0x%08h", what, data,
                                       expect_data));
    endtask

    task automatic check_write(input logic [addr_width-1:0] addr, input logic [31:0] data,
                               input logic [3:0] strb, input logic [1:0] expect_resp,
                               input string what);
        logic [1:0] resp;
        axil_write(addr, data, strb, resp);
        assert (resp == expect_resp)
            else value_error($sformatf("%s: response %0d, expected %0d", what, resp,
                                       expect_resp));
    endtask

    task automatic launch_job(input div_job_t job, output logic [1:0] resp);
        check_write(reg_dividend, job.dividend, 4'hF, resp_okay, "dividend write");
        check_write(reg_divisor, job.divisor, 4'hF, resp_okay, "divisor write");
        axil_write(reg_launch, 32'h1, 4'hF, resp);
    endtask

    task automatic wait_for_result();
        logic [31:0] status;
        logic [1:0]  resp;
        do begin
            axil_read(reg_status, status, resp);
        end while (!status[status_result_bit]);
    endtask

    task automatic check_result(input div_job_t job, input string what);
        div_result_t expected;
        expected = expected_result(job);
        wait_for_result();
        check_read(reg_quotient, expected.quotient, resp_okay, {what, " quotient"});
        check_read(reg_remainder, expected.remainder, resp_okay, {what, " remainder"});
    endtask

    initial begin
        div_job_t    job;
        div_job_t    pending[$];
        logic [31:0] status;
        logic [1:0]  resp;

        axil_req    = '0;
        lfsr_state  = 32'h53f2;
        cycle_count = 0;
        @(negedge clock);
        while (reset) begin
            @(negedge clock);
        end

        check_read(reg_status, 32'h0, resp_okay, "status after reset");
        check_read(reg_dividend, 32'h0, resp_okay, "dividend after reset");
        check_read(reg_divisor, 32'h0, resp_okay, "divisor after reset");

        check_write(reg_dividend, 32'h1234_5678, 4'hF, resp_okay, "dividend write");
        check_read(reg_dividend, 32'h1234_5678, resp_okay, "dividend readback");
        check_write(reg_dividend, 32'hAABB_CCDD, 4'b0101, resp_okay, "dividend byte write");
        check_read(reg_dividend, 32'h12BB_56DD, resp_okay, "dividend byte readback");
        check_write(reg_divisor, 32'hCAFE_F00D, 4'b1100, resp_okay, "divisor byte write");
        check_read(reg_divisor, 32'hCAFE_0000, resp_okay, "divisor byte readback");

        for (int n = 0; n < 20; n++) begin
            draw_bits(32, job.dividend);
            draw_bits(20, job.divisor);
            launch_job(job, resp);
            assert (resp == resp_okay)
                else value_error($sformatf("launch %0d: response %0d", n, resp));
            check_result(job, $sformatf("job %0d", n));
            check_read(reg_status, 32'h0, resp_okay, "status after pop");
        end

        job = '{dividend: 32'h0012_3456, divisor: '0};
        launch_job(job, resp);
        wait_for_result();
        check_read(reg_status, (32'h1 << status_result_bit) | (32'h1 << status_dbz_bit),
                   resp_okay, "status with zero divisor");
        check_result(job, "zero divisor");

        // nothing is read back here, so the divider and both queues fill up.
        while (pending.size() < capacity) begin
            draw_bits(32, job.dividend);
            draw_bits(16, job.divisor);
            job.divisor[0] = 1'b1;
            launch_job(job, resp);
            assert (resp == resp_okay || resp == resp_slverr)
                else value_error($sformatf("queued launch: response %0d", resp));
            if (resp == resp_okay) begin
                pending.push_back(job);
            end
        end
        axil_read(reg_status, status, resp);
        assert (status[status_full_bit] && status[status_result_bit])
            else value_error($sformatf("status 0x%08h with all queues full", status));
        launch_job(job, resp);
        assert (resp == resp_slverr)
            else value_error($sformatf("launch into full queue: response %0d", resp));
        foreach (pending[i]) begin
            check_result(pending[i], $sformatf("queued job %0d", i));
        end
        check_read(reg_status, 32'h0, resp_okay, "status after drain");

        check_read(reg_remainder, 32'h0, resp_slverr, "remainder with no result");
        check_read(reg_quotient, 32'h0, resp_slverr, "quotient with no result");
        check_read(8'h20, 32'h0, resp_decerr, "read of unmapped address");
        check_write(8'h20, 32'h0, 4'hF, resp_decerr, "write to unmapped address");
        check_write(reg_status, 32'h0, 4'hF, resp_decerr, "write to status");

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
source/div_arith_pkg.sv
source/axil_regs_pkg.sv
source/sync_queue.sv
source/nonrestoring_divider.sv
source/axil_div_regs.sv
source/div_accel_top.sv
test/clock_gen.sv
test/div_accel_tb.sv

//--- Bender.yml
package:
  name: div_accel

sources:
  - source/div_arith_pkg.sv
  - source/axil_regs_pkg.sv
  - source/sync_queue.sv
  - source/nonrestoring_divider.sv
  - source/axil_div_regs.sv
  - source/div_accel_top.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/div_accel_tb.sv
